/* rtl/dtm_pkg.sv */
`default_nettype none

package dtm_pkg;

    // IEEE 1149.1 TAP states, encoding follows the usual DR/IR split
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'h0,
        RUN_TEST_IDLE    = 4'h1,
        SELECT_DR_SCAN   = 4'h2,
        CAPTURE_DR       = 4'h3,
        SHIFT_DR         = 4'h4,
        EXIT1_DR         = 4'h5,
        PAUSE_DR         = 4'h6,
        EXIT2_DR         = 4'h7,
        UPDATE_DR        = 4'h8,
        SELECT_IR_SCAN   = 4'h9,
        CAPTURE_IR       = 4'hA,
        SHIFT_IR         = 4'hB,
        EXIT1_IR         = 4'hC,
        PAUSE_IR         = 4'hD,
        EXIT2_IR         = 4'hE,
        UPDATE_IR        = 4'hF
    } tap_state_t;

    // instruction register, 5 bits as the debug spec asks
    localparam int IR_WIDTH = 5;
    localparam logic [IR_WIDTH-1:0] IR_IDCODE  = 5'b00001;
    localparam logic [IR_WIDTH-1:0] IR_DMI     = 5'b10001;
    localparam logic [IR_WIDTH-1:0] IR_CUSTOM  = 5'b01010;
    localparam logic [IR_WIDTH-1:0] IR_BYPASS  = 5'b11111;
    localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 5'b00001;

    localparam logic [31:0] IDCODE_VALUE       = 32'h1234_5678;
    localparam logic [31:0] CUSTOM_RESET_VALUE = 32'h0A0B_0C0D;

    // dmi scan chain layout
    localparam int DMI_ADDR_WIDTH = 10;
    localparam int DMI_DATA_WIDTH = 32;
    localparam int DMI_OP_WIDTH   = 2;
    localparam int DMI_WIDTH      = DMI_ADDR_WIDTH + DMI_DATA_WIDTH + DMI_OP_WIDTH;

    // op field as written by the debugger
    typedef enum logic [DMI_OP_WIDTH-1:0] {
        OP_NOP      = 2'd0,
        OP_READ     = 2'd1,
        OP_WRITE    = 2'd2,
        OP_RESERVED = 2'd3
    } dmi_op_t;

    // op field as returned on capture
    localparam logic [DMI_OP_WIDTH-1:0] DMI_STATUS_SUCCESS = 2'd0;
    localparam logic [DMI_OP_WIDTH-1:0] DMI_STATUS_BUSY    = 2'd3;

    // msb first: addr, data, op
    typedef struct packed {
        logic [DMI_ADDR_WIDTH-1:0] addr;
        logic [DMI_DATA_WIDTH-1:0] data;
        logic [DMI_OP_WIDTH-1:0]   op;
    } dmi_word_t;

endpackage

`default_nettype wire

/* rtl/tap_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface tap_ctrl_if import dtm_pkg::*; ();

    // current controller state, changes one cycle after tck_rise
    tap_state_t state;

    // single clk-cycle strobes for the TCK edges
    logic tck_rise;
    logic tck_fall;

    // synchronized TDI, valid together with tck_rise
    logic tdi;

    modport ctrl (
        output state,
        output tck_rise,
        output tck_fall,
        output tdi
    );

    // register blocks only look
    modport regs (
        input state,
        input tck_rise,
        input tck_fall,
        input tdi
    );

endinterface

`default_nettype wire

/* rtl/jtag_pin_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module jtag_pin_sync (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  jtag_clk_i,
    input  wire  jtag_tms_i,
    input  wire  jtag_tdi_i,
    output logic tck_rise_o,
    output logic tck_fall_o,
    output logic tms_o,
    output logic tdi_o
);

    // two stage synchronizers, bit 1 is the stable sample
    logic [1:0] tck_sync;
    logic [1:0] tms_sync;
    logic [1:0] tdi_sync;
    // previous stable TCK sample for edge detect
    logic       tck_last;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tck_sync   <= 2'b00;
            tms_sync   <= 2'b11;
            tdi_sync   <= 2'b00;
            tck_last   <= 1'b0;
            tck_rise_o <= 1'b0;
            tck_fall_o <= 1'b0;
            // TMS idles high
            tms_o      <= 1'b1;
            tdi_o      <= 1'b0;
        end
        else
        begin
            tck_sync   <= {tck_sync[0], jtag_clk_i};
            tms_sync   <= {tms_sync[0], jtag_tms_i};
            tdi_sync   <= {tdi_sync[0], jtag_tdi_i};
            tck_last   <= tck_sync[1];
            // third stage, strobes land 3 clk after the pin edge
            tck_rise_o <= tck_sync[1] & ~tck_last;
            tck_fall_o <= ~tck_sync[1] & tck_last;
            // keep TMS/TDI in step with the strobes
            tms_o      <= tms_sync[1];
            tdi_o      <= tdi_sync[1];
        end
    end

endmodule

`default_nettype wire

/* rtl/tap_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module tap_controller import dtm_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        tck_rise_i,
    input  wire        tck_fall_i,
    input  wire        tms_i,
    input  wire        tdi_i,
    tap_ctrl_if.ctrl   tap
);

    tap_state_t state_q;
    tap_state_t state_d;

    // 1149.1 transition table, TMS picks the branch
    always_comb
    begin
        case (state_q)
            TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   state_d = tms_i ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         state_d = tms_i ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         state_d = tms_i ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         state_d = tms_i ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            // IR column
            SELECT_IR_SCAN:   state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         state_d = tms_i ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         state_d = tms_i ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         state_d = tms_i ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    // only advance on a TCK rising edge
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= TEST_LOGIC_RESET;
        end
        else if (tck_rise_i)
        begin
            state_q <= state_d;
        end
    end

    // register blocks see the old state together with the strobe
    assign tap.state    = state_q;
    assign tap.tck_rise = tck_rise_i;
    assign tap.tck_fall = tck_fall_i;
    assign tap.tdi      = tdi_i;

endmodule

`default_nettype wire

/* rtl/tap_data_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module tap_data_regs import dtm_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    tap_ctrl_if.regs   tap,
    input  wire        dmi_tdo_bit_i,
    output logic       dmi_sel_o,
    output logic       jtag_tdo_o
);

    logic [IR_WIDTH-1:0] ir_shift;
    logic [IR_WIDTH-1:0] ir_q;
    // shared by IDCODE and the custom register
    logic [31:0]         dr_shift;
    logic                bypass_bit;
    logic [31:0]         custom_q;

    // register actions decoded from state plus edge strobe
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;

    assign capture_ir = tap.tck_rise && (tap.state == CAPTURE_IR);
    assign shift_ir   = tap.tck_rise && (tap.state == SHIFT_IR);
    assign update_ir  = tap.tck_fall && (tap.state == UPDATE_IR);
    assign capture_dr = tap.tck_rise && (tap.state == CAPTURE_DR);
    assign shift_dr   = tap.tck_rise && (tap.state == SHIFT_DR);
    assign update_dr  = tap.tck_fall && (tap.state == UPDATE_DR);

    assign dmi_sel_o = (ir_q == IR_DMI);

    // IR and DR shift chains
    always_ff @(posedge clk)
    begin
        if (capture_ir)
        begin
            ir_shift <= IR_CAPTURE;
        end
        else if (shift_ir)
        begin
            ir_shift <= {tap.tdi, ir_shift[IR_WIDTH-1:1]};
        end

        if (capture_dr)
        begin
            // undefined codes and DMI capture 0 into bypass
            case (ir_q)
                IR_IDCODE: dr_shift <= IDCODE_VALUE;
                IR_CUSTOM: dr_shift <= custom_q;
                default:   bypass_bit <= 1'b0;
            endcase
        end
        else if (shift_dr)
        begin
            dr_shift   <= {tap.tdi, dr_shift[31:1]};
            bypass_bit <= tap.tdi;
        end
    end

    // instruction, custom register and TDO
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ir_q       <= IR_IDCODE;
            custom_q   <= CUSTOM_RESET_VALUE;
            jtag_tdo_o <= 1'b0;
        end
        else
        begin
            // TLR also forces IDCODE
            if (tap.state == TEST_LOGIC_RESET)
            begin
                ir_q <= IR_IDCODE;
            end
            else if (update_ir)
            begin
                ir_q <= ir_shift;
            end

            if (update_dr && (ir_q == IR_CUSTOM))
            begin
                custom_q <= dr_shift;
            end

            // drive lsb on falling TCK so it is stable at the next rise
            if (tap.tck_fall && (tap.state == SHIFT_IR))
            begin
                jtag_tdo_o <= ir_shift[0];
            end
            else if (tap.tck_fall && (tap.state == SHIFT_DR))
            begin
                case (ir_q)
                    IR_IDCODE, IR_CUSTOM: jtag_tdo_o <= dr_shift[0];
                    IR_DMI:               jtag_tdo_o <= dmi_tdo_bit_i;
                    default:              jtag_tdo_o <= bypass_bit;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dmi_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module dmi_bridge import dtm_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    tap_ctrl_if.regs                   tap,
    input  wire                        dmi_sel_i,
    output logic                       dmi_tdo_bit_o,
    input  wire                        bus_ack_i,
    input  wire  [DMI_DATA_WIDTH-1:0]  bus_rdata_i,
    output logic                       bus_rd_o,
    output logic                       bus_wr_o,
    output logic [DMI_ADDR_WIDTH-1:0]  bus_addr_o,
    output logic [DMI_DATA_WIDTH-1:0]  bus_wdata_o
);

    dmi_word_t                 dmi_shift;
    // read data after a read, else request data
    logic [DMI_DATA_WIDTH-1:0] result_q;
    logic                      pending_q;
    logic                      pending_rd_q;
    dmi_op_t                   req_op;
    logic                      update_req;

    assign req_op = dmi_op_t'(dmi_shift.op);

    // single back-pressure point, busy requests are dropped
    assign update_req = tap.tck_fall && (tap.state == UPDATE_DR) && dmi_sel_i
                        && !pending_q && ((req_op == OP_READ) || (req_op == OP_WRITE));

    assign dmi_tdo_bit_o = dmi_shift[0];

    always_ff @(posedge clk)
    begin
        if (tap.tck_rise && (tap.state == CAPTURE_DR) && dmi_sel_i)
        begin
            dmi_shift.addr <= bus_addr_o;
            dmi_shift.data <= result_q;
            dmi_shift.op   <= pending_q ? DMI_STATUS_BUSY : DMI_STATUS_SUCCESS;
        end
        else if (tap.tck_rise && (tap.state == SHIFT_DR) && dmi_sel_i)
        begin
            dmi_shift <= dmi_word_t'({tap.tdi, dmi_shift[DMI_WIDTH-1:1]});
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pending_q    <= 1'b0;
            pending_rd_q <= 1'b0;
            bus_rd_o     <= 1'b0;
            bus_wr_o     <= 1'b0;
            bus_addr_o   <= '0;
            bus_wdata_o  <= '0;
            result_q     <= '0;
        end
        else
        begin
            // strobes are single cycle
            bus_rd_o <= 1'b0;
            bus_wr_o <= 1'b0;
            if (update_req)
            begin
                bus_addr_o   <= dmi_shift.addr;
                bus_wdata_o  <= dmi_shift.data;
                result_q     <= dmi_shift.data;
                pending_q    <= 1'b1;
                pending_rd_q <= (req_op == OP_READ);
                bus_rd_o     <= (req_op == OP_READ);
                bus_wr_o     <= (req_op == OP_WRITE);
            end
            else if (bus_ack_i && pending_q)
            begin
                pending_q <= 1'b0;
                // write ack keeps the data field
                if (pending_rd_q)
                begin
                    result_q <= bus_rdata_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/jtag_dtm_top.sv */
`timescale 1ns/100ps
`default_nettype none

module jtag_dtm_top import dtm_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        jtag_clk_i,
    input  wire                        jtag_tms_i,
    input  wire                        jtag_tdi_i,
    output logic                       jtag_tdo_o,
    input  wire                        bus_ack_i,
    input  wire  [DMI_DATA_WIDTH-1:0]  bus_rdata_i,
    output logic                       bus_rd_o,
    output logic                       bus_wr_o,
    output logic [DMI_ADDR_WIDTH-1:0]  bus_addr_o,
    output logic [DMI_DATA_WIDTH-1:0]  bus_wdata_o
);

    // pins after synchronization
    logic tck_rise;
    logic tck_fall;
    logic tms_sync;
    logic tdi_sync;
    // between IR decode and dmi chain
    logic dmi_sel;
    logic dmi_tdo_bit;

    tap_ctrl_if tap ();

    jtag_pin_sync u_pin_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .jtag_clk_i (jtag_clk_i),
        .jtag_tms_i (jtag_tms_i),
        .jtag_tdi_i (jtag_tdi_i),
        .tck_rise_o (tck_rise),
        .tck_fall_o (tck_fall),
        .tms_o      (tms_sync),
        .tdi_o      (tdi_sync)
    );

    tap_controller u_tap_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .tck_rise_i (tck_rise),
        .tck_fall_i (tck_fall),
        .tms_i      (tms_sync),
        .tdi_i      (tdi_sync),
        .tap        (tap.ctrl)
    );

    tap_data_regs u_data_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .tap           (tap.regs),
        .dmi_tdo_bit_i (dmi_tdo_bit),
        .dmi_sel_o     (dmi_sel),
        .jtag_tdo_o    (jtag_tdo_o)
    );

    dmi_bridge u_dmi (
        .clk           (clk),
        .rst_n         (rst_n),
        .tap           (tap.regs),
        .dmi_sel_i     (dmi_sel),
        .dmi_tdo_bit_o (dmi_tdo_bit),
        .bus_ack_i     (bus_ack_i),
        .bus_rdata_i   (bus_rdata_i),
        .bus_rd_o      (bus_rd_o),
        .bus_wr_o      (bus_wr_o),
        .bus_addr_o    (bus_addr_o),
        .bus_wdata_o   (bus_wdata_o)
    );

endmodule

`default_nettype wire

/* bench/tb_jtag_dtm.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_jtag_dtm import dtm_pkg::*; ();

    localparam int WAIT_LIMIT = 4000;

    logic                      clk = 1'b0;
    logic                      rst_n = 1'b0;
    logic                      jtag_clk = 1'b0;
    logic                      jtag_tms = 1'b1;
    logic                      jtag_tdi = 1'b0;
    logic                      jtag_tdo;
    logic                      bus_ack_i = 1'b0;
    logic [DMI_DATA_WIDTH-1:0] bus_rdata_i = '0;
    logic                      bus_rd_o;
    logic                      bus_wr_o;
    logic [DMI_ADDR_WIDTH-1:0] bus_addr_o;
    logic [DMI_DATA_WIDTH-1:0] bus_wdata_o;

    // bus responder counters and the controls set by the tests
    int                        rd_count = 0;
    int                        wr_count = 0;
    int                        delay_cnt = 0;
    int                        ack_delay = 3;
    logic                      ack_hold = 1'b0;
    logic                      req_open = 1'b0;
    logic [31:0]               rdata_next = '0;
    logic [DMI_ADDR_WIDTH-1:0] seen_addr = '0;
    logic [DMI_DATA_WIDTH-1:0] seen_wdata = '0;

    jtag_dtm_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .jtag_clk_i  (jtag_clk),
        .jtag_tms_i  (jtag_tms),
        .jtag_tdi_i  (jtag_tdi),
        .jtag_tdo_o  (jtag_tdo),
        .bus_ack_i   (bus_ack_i),
        .bus_rdata_i (bus_rdata_i),
        .bus_rd_o    (bus_rd_o),
        .bus_wr_o    (bus_wr_o),
        .bus_addr_o  (bus_addr_o),
        .bus_wdata_o (bus_wdata_o)
    );

    always #5 clk = ~clk;

    // logs each strobe and acks after ack_delay cycles unless held
    always @(posedge clk)
    begin
        bus_ack_i <= 1'b0;
        if (rst_n && (bus_rd_o || bus_wr_o))
        begin
            $display("bus %s addr %h data %h", bus_rd_o ? "read" : "write",
                     bus_addr_o, bus_wdata_o);
            if (bus_rd_o)
            begin
                rd_count <= rd_count + 1;
            end
            if (bus_wr_o)
            begin
                wr_count <= wr_count + 1;
            end
            seen_addr  <= bus_addr_o;
            seen_wdata <= bus_wdata_o;
            req_open   <= 1'b1;
            delay_cnt  <= ack_delay;
        end
        else if (req_open && !ack_hold)
        begin
            if (delay_cnt == 0)
            begin
                bus_ack_i   <= 1'b1;
                bus_rdata_i <= rdata_next;
                req_open    <= 1'b0;
            end
            else
            begin
                delay_cnt <= delay_cnt - 1;
            end
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_dmi(input string name, input dmi_word_t exp, input dmi_word_t act);
        if (act !== exp)
        begin
            stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_ir(input string name, input logic [IR_WIDTH-1:0] exp,
                            input logic [IR_WIDTH-1:0] act);
        if (act !== exp)
        begin
            stop_on_error($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            stop_on_error($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
        end
    endtask

    // one TCK period of 5 clk low and 5 clk high with tdo sampled just before the rise
    task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
        repeat (2) @(posedge clk);
        jtag_tms <= tms;
        jtag_tdi <= tdi;
        repeat (3) @(posedge clk);
        tdo = jtag_tdo;
        jtag_clk <= 1'b1;
        repeat (5) @(posedge clk);
        jtag_clk <= 1'b0;
    endtask

    task automatic idle_tcks(input int n);
        logic unused_tdo;
        repeat (n) tck_cycle(1'b0, 1'b0, unused_tdo);
    endtask

    // five TMS high clocks reach TLR from anywhere and then park in idle
    task automatic reset_tap();
        logic unused_tdo;
        repeat (5) tck_cycle(1'b1, 1'b0, unused_tdo);
        tck_cycle(1'b0, 1'b0, unused_tdo);
    endtask

    // idle to idle scan with lsb first
    task automatic scan(input logic is_ir, input logic [63:0] din, input int nbits,
                        output logic [63:0] dout);
        logic bit_out;
        int   i;
        dout = '0;
        // select-DR and optionally select-IR
        tck_cycle(1'b1, 1'b0, bit_out);
        if (is_ir)
        begin
            tck_cycle(1'b1, 1'b0, bit_out);
        end
        // into capture and then capture and enter shift
        tck_cycle(1'b0, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        for (i = 0; i < nbits; i++)
        begin
            tck_cycle(i == nbits - 1, din[i], bit_out);
            dout[i] = bit_out;
        end
        // exit1 to update and back to idle
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
    endtask

    task automatic wait_strobes(input string name, input int want_rd, input int want_wr);
        int cycles;
        cycles = 0;
        while ((rd_count != want_rd || wr_count != want_wr) && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (rd_count != want_rd || wr_count != want_wr)
        begin
            stop_on_error({name, ": expected bus strobe never arrived"});
        end
    endtask

    task automatic wait_ack_done(input string name);
        int cycles;
        cycles = 0;
        while (req_open && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (req_open)
        begin
            stop_on_error({name, ": bus request was never acknowledged"});
        end
    endtask

    task automatic test_idcode_reset();
        logic [63:0] dout;
        reset_tap();
        scan(1'b0, 64'd0, 32, dout);
        check_word("idcode_after_reset", IDCODE_VALUE, dout[31:0]);
        scan(1'b1, {59'd0, IR_BYPASS}, IR_WIDTH, dout);
        // zeros through the bypass flop give zeros
        scan(1'b0, 64'd0, 32, dout);
        check_word("bypass_selected", 32'd0, dout[31:0]);
        reset_tap();
        scan(1'b0, 64'd0, 32, dout);
        check_word("idcode_after_tlr", IDCODE_VALUE, dout[31:0]);
    endtask

    task automatic test_ir_bypass();
        logic [63:0] dout;
        logic [31:0] pattern;
        scan(1'b1, {59'd0, IR_BYPASS}, IR_WIDTH, dout);
        check_ir("ir_capture", IR_CAPTURE, dout[IR_WIDTH-1:0]);
        pattern = $urandom;
        // one extra bit to flush the pattern through the bypass flop
        scan(1'b0, {32'd0, pattern}, 33, dout);
        check_bit("bypass_first_bit", 1'b0, dout[0]);
        check_word("bypass_delay", pattern, dout[32:1]);
    endtask

    task automatic test_custom_reg();
        logic [63:0] dout;
        logic [31:0] expect_old;
        logic [31:0] word;
        scan(1'b1, {59'd0, IR_CUSTOM}, IR_WIDTH, dout);
        expect_old = CUSTOM_RESET_VALUE;
        repeat (8)
        begin
            word = $urandom;
            scan(1'b0, {32'd0, word}, 32, dout);
            check_word("custom_readback", expect_old, dout[31:0]);
            expect_old = word;
        end
        scan(1'b0, 64'd0, 32, dout);
        check_word("custom_last_word", expect_old, dout[31:0]);
    endtask

    task automatic test_dmi_write();
        logic [63:0] dout;
        logic [31:0] r;
        dmi_word_t   req;
        dmi_word_t   exp;
        int          rd0;
        int          wr0;
        scan(1'b1, {59'd0, IR_DMI}, IR_WIDTH, dout);
        ack_delay <= 3;
        ack_hold  <= 1'b0;
        r = $urandom;
        req.addr = r[DMI_ADDR_WIDTH-1:0];
        req.data = $urandom;
        req.op   = OP_WRITE;
        rd0 = rd_count;
        wr0 = wr_count;
        scan(1'b0, {20'd0, req}, DMI_WIDTH, dout);
        wait_strobes("dmi_write", rd0, wr0 + 1);
        wait_ack_done("dmi_write");
        idle_tcks(5);
        check_word("dmi_write_wr_count", wr0 + 1, wr_count);
        check_word("dmi_write_rd_count", rd0, rd_count);
        check_word("dmi_write_addr", {22'd0, req.addr}, {22'd0, seen_addr});
        check_word("dmi_write_data", req.data, seen_wdata);
        // nop and reserved ops must stay quiet on the bus
        req.op = OP_NOP;
        scan(1'b0, {20'd0, req}, DMI_WIDTH, dout);
        // write ack leaves the request data in the data field
        exp.addr = req.addr;
        exp.data = req.data;
        exp.op   = DMI_STATUS_SUCCESS;
        check_dmi("dmi_write_capture", exp, dmi_word_t'(dout[DMI_WIDTH-1:0]));
        idle_tcks(20);
        req.op = OP_RESERVED;
        scan(1'b0, {20'd0, req}, DMI_WIDTH, dout);
        idle_tcks(20);
        check_word("dmi_nop_wr_count", wr0 + 1, wr_count);
        check_word("dmi_nop_rd_count", rd0, rd_count);
    endtask

    task automatic test_dmi_read();
        logic [63:0] dout;
        logic [31:0] r;
        dmi_word_t   req;
        dmi_word_t   exp;
        int          rd0;
        int          wr0;
        ack_hold   <= 1'b1;
        rdata_next <= $urandom;
        r = $urandom;
        req.addr = r[DMI_ADDR_WIDTH-1:0];
        req.data = $urandom;
        req.op   = OP_READ;
        rd0 = rd_count;
        wr0 = wr_count;
        scan(1'b0, {20'd0, req}, DMI_WIDTH, dout);
        wait_strobes("dmi_read", rd0 + 1, wr0);
        check_word("dmi_read_addr", {22'd0, req.addr}, {22'd0, seen_addr});
        // data field still holds the request data while pending
        exp.addr = req.addr;
        exp.data = req.data;
        exp.op   = DMI_STATUS_BUSY;
        r = $urandom;
        scan(1'b0, {20'd0, r[DMI_ADDR_WIDTH-1:0], r, OP_READ}, DMI_WIDTH, dout);
        check_dmi("dmi_read_busy", exp, dmi_word_t'(dout[DMI_WIDTH-1:0]));
        idle_tcks(10);
        check_word("dmi_busy_rd_count", rd0 + 1, rd_count);
        ack_hold <= 1'b0;
        wait_ack_done("dmi_read");
        exp.data = rdata_next;
        exp.op   = DMI_STATUS_SUCCESS;
        scan(1'b0, 64'd0, DMI_WIDTH, dout);
        check_dmi("dmi_read_result", exp, dmi_word_t'(dout[DMI_WIDTH-1:0]));
        check_word("dmi_read_wr_count", wr0, wr_count);
    endtask

    initial
    begin
        void'($urandom(32'h5555_5fd8));
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        test_idcode_reset();
        test_ir_bypass();
        test_custom_reg();
        test_dmi_write();
        test_dmi_read();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/dtm_pkg.sv
rtl/tap_ctrl_if.sv
rtl/jtag_pin_sync.sv
rtl/tap_controller.sv
rtl/tap_data_regs.sv
rtl/dmi_bridge.sv
rtl/jtag_dtm_top.sv
bench/tb_jtag_dtm.sv

/* Makefile */
# Verilator build and run for the JTAG DTM testbench

VERILATOR ?= verilator
TOP       ?= tb_jtag_dtm
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
